// ==== Makefile ====
LOG := sim.log

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run the testbench, check $(LOG)"
	@echo "make clean  remove obj_dir and $(LOG)"

test:
	verilator --binary --timing -Wno-fatal --top-module tb_noc_router -f list.f
	./obj_dir/Vtb_noc_router 2>&1 | tee $(LOG)
	@if grep -q "sim failed" $(LOG); then exit 1; fi
	@grep -q "sim passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== list.f ====
+incdir+test
source/noc_pkg.sv
source/flit_fifo.sv
source/xy_route_select.sv
source/wormhole_arbiter.sv
source/noc_router.sv
test/tb_noc_router.sv

// ==== source/flit_fifo.sv ====
/* Input flit FIFO: circular buffer with valid/ready on both sides,
   one cycle of latency and no data fall-through */
`timescale 1ns/1ps
`default_nettype none

module flit_fifo #(
  parameter int unsigned Depth = 2
) (
  input  logic           clk_i,
  input  logic           rst_n_i,
  input  logic           valid_i,
  output logic           ready_o,
  input  noc_pkg::flit_t data_i,
  output logic           valid_o,
  input  logic           ready_i,
  output noc_pkg::flit_t data_o
);
  import noc_pkg::*;

  flit_t                      mem_q [Depth];
  logic [$clog2(Depth)-1:0]   rd_ptr_q;
  logic [$clog2(Depth)-1:0]   wr_ptr_q;
  logic [$clog2(Depth+1)-1:0] count_q;
  logic                       push;
  logic                       pop;

  assign valid_o = (count_q != '0);
  // A full buffer still takes a flit while its head is leaving
  assign ready_o = (count_q != Depth) || ready_i;
  assign data_o  = mem_q[rd_ptr_q];

  assign push = valid_i & ready_o;
  assign pop  = valid_o & ready_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == Depth - 1) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == Depth - 1) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // Storage
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

endmodule

`default_nettype wire

// ==== source/noc_pkg.sv ====
/* Shared router definitions: port numbering, mesh coordinate and flit types,
   and the router-wide constants */
`default_nettype none

package noc_pkg;

  // Router ports, the local port last
  localparam int unsigned NumPorts = 5;

  typedef enum logic [2:0] {
    North = 3'd0,
    East  = 3'd1,
    South = 3'd2,
    West  = 3'd3,
    Eject = 3'd4
  } route_dir_e;

  // Mesh coordinate, y grows towards North
  localparam int unsigned CoordWidth = 3;

  typedef struct packed {
    logic [CoordWidth-1:0] x;
    logic [CoordWidth-1:0] y;
  } coord_t;

  localparam int unsigned FlitPayloadWidth = 16;

  typedef struct packed {
    coord_t dst;
    coord_t src;
    logic   last;
  } flit_hdr_t;

  typedef struct packed {
    flit_hdr_t                   hdr;
    logic [FlitPayloadWidth-1:0] payload;
  } flit_t;

  // One bit per output port, one-hot for unicast
  typedef logic [NumPorts-1:0] port_mask_t;

  localparam int unsigned InFifoDepth = 2;

endpackage

`default_nettype wire

// ==== source/noc_router.sv ====
/* Five-port XY mesh router: input FIFOs and route selection, masked
   crossbar without loopback or Y-to-X turns, wormhole output arbiters */
`timescale 1ns/1ps
`default_nettype none

module noc_router (
  input  logic                                    clk_i,
  input  logic                                    rst_n_i,
  input  noc_pkg::coord_t                         xy_id_i,
  input  logic           [noc_pkg::NumPorts-1:0] valid_i,
  output logic           [noc_pkg::NumPorts-1:0] ready_o,
  input  noc_pkg::flit_t [noc_pkg::NumPorts-1:0] data_i,
  output logic           [noc_pkg::NumPorts-1:0] valid_o,
  input  logic           [noc_pkg::NumPorts-1:0] ready_i,
  output noc_pkg::flit_t [noc_pkg::NumPorts-1:0] data_o
);
  import noc_pkg::*;

  flit_t      [NumPorts-1:0] in_data;
  flit_t      [NumPorts-1:0] in_routed_data;
  logic       [NumPorts-1:0] in_valid;
  logic       [NumPorts-1:0] in_ready;
  port_mask_t [NumPorts-1:0] route_mask;

  // Crossbar signals indexed [out][in], returned readies [in][out]
  logic  [NumPorts-1:0][NumPorts-1:0] masked_valid;
  logic  [NumPorts-1:0][NumPorts-1:0] masked_ready;
  logic  [NumPorts-1:0][NumPorts-1:0] ready_to_in;
  flit_t [NumPorts-1:0][NumPorts-1:0] masked_data;

  for (genvar in = 0; in < NumPorts; in++) begin : gen_input
    flit_fifo #(
      .Depth ( InFifoDepth )
    ) u_in_fifo (
      .clk_i   ( clk_i        ),
      .rst_n_i ( rst_n_i      ),
      .valid_i ( valid_i[in]  ),
      .ready_o ( ready_o[in]  ),
      .data_i  ( data_i[in]   ),
      .valid_o ( in_valid[in] ),
      .ready_i ( in_ready[in] ),
      .data_o  ( in_data[in]  )
    );

    xy_route_select u_route_select (
      .clk_i   ( clk_i              ),
      .rst_n_i ( rst_n_i            ),
      .xy_id_i ( xy_id_i            ),
      .valid_i ( in_valid[in]       ),
      .ready_i ( in_ready[in]       ),
      .data_i  ( in_data[in]        ),
      .data_o  ( in_routed_data[in] ),
      .route_o ( route_mask[in]     )
    );
  end

  for (genvar in = 0; in < NumPorts; in++) begin : gen_xbar_in
    for (genvar out = 0; out < NumPorts; out++) begin : gen_xbar_out
      // Loopback and Y-to-X turns cannot occur under XY routing
      if ((in == out) ||
          ((in == North || in == South) && (out == East || out == West))) begin : gen_no_conn
        assign masked_valid[out][in] = 1'b0;
        assign masked_data[out][in]  = '0;
        assign ready_to_in[in][out]  = 1'b0;
      end else begin : gen_conn
        assign masked_valid[out][in] = in_valid[in] & route_mask[in][out];
        assign masked_data[out][in]  = in_routed_data[in];
        assign ready_to_in[in][out]  = masked_ready[out][in];
      end
    end

    // Unicast, so only the routed output answers
    assign in_ready[in] = |(ready_to_in[in] & route_mask[in]);
  end

  for (genvar out = 0; out < NumPorts; out++) begin : gen_output
    wormhole_arbiter u_out_arb (
      .clk_i   ( clk_i              ),
      .rst_n_i ( rst_n_i            ),
      .valid_i ( masked_valid[out]  ),
      .ready_o ( masked_ready[out]  ),
      .data_i  ( masked_data[out]   ),
      .valid_o ( valid_o[out]       ),
      .ready_i ( ready_i[out]       ),
      .data_o  ( data_o[out]        )
    );
  end

endmodule

`default_nettype wire

// ==== source/wormhole_arbiter.sv ====
/* Round-robin output arbiter that stays locked to one input
   from the head flit to the last flit of a packet */
`timescale 1ns/1ps
`default_nettype none

module wormhole_arbiter (
  input  logic                                    clk_i,
  input  logic                                    rst_n_i,
  input  logic           [noc_pkg::NumPorts-1:0] valid_i,
  output logic           [noc_pkg::NumPorts-1:0] ready_o,
  input  noc_pkg::flit_t [noc_pkg::NumPorts-1:0] data_i,
  output logic                                    valid_o,
  input  logic                                    ready_i,
  output noc_pkg::flit_t                          data_o
);
  import noc_pkg::*;

  route_dir_e rr_q;
  route_dir_e lock_idx_q;
  logic       lock_q;
  logic       hold_q;
  route_dir_e pick_idx;
  route_dir_e sel_idx;
  route_dir_e next_rr;
  logic       transfer;

  // First requester at or after the priority pointer
  always_comb begin
    int unsigned idx;
    logic        found;
    pick_idx = rr_q;
    found    = 1'b0;
    for (int unsigned k = 0; k < NumPorts; k++) begin
      idx = int'(rr_q) + k;
      if (idx >= NumPorts) begin
        idx = idx - NumPorts;
      end
      if (!found && valid_i[idx]) begin
        pick_idx = route_dir_e'(idx);
        found    = 1'b1;
      end
    end
  end

  // Locked packets and stalled flits keep the output
  assign sel_idx = (lock_q || hold_q) ? lock_idx_q : pick_idx;

  assign valid_o  = valid_i[sel_idx];
  assign data_o   = data_i[sel_idx];
  assign transfer = valid_o & ready_i;

  always_comb begin
    ready_o          = '0;
    ready_o[sel_idx] = ready_i & valid_i[sel_idx];
  end

  assign next_rr = (sel_idx == Eject) ? North : route_dir_e'(sel_idx + 1'b1);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rr_q       <= North;
      lock_q     <= 1'b0;
      hold_q     <= 1'b0;
      lock_idx_q <= North;
    end else if (transfer) begin
      hold_q <= 1'b0;
      if (data_o.hdr.last) begin
        lock_q <= 1'b0;
        // Winner drops to lowest priority
        rr_q   <= next_rr;
      end else begin
        lock_q     <= 1'b1;
        lock_idx_q <= sel_idx;
      end
    end else if (valid_o) begin
      // A stalled flit keeps its grant until it is taken
      hold_q     <= 1'b1;
      lock_idx_q <= sel_idx;
    end
  end

endmodule

`default_nettype wire

// ==== source/xy_route_select.sv ====
/* XY dimension-order route selection on head flits, with the route
   held until the last flit of the packet has passed */
`timescale 1ns/1ps
`default_nettype none

module xy_route_select (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  noc_pkg::coord_t     xy_id_i,
  input  logic                valid_i,
  input  logic                ready_i,
  input  noc_pkg::flit_t      data_i,
  output noc_pkg::flit_t      data_o,
  output noc_pkg::port_mask_t route_o
);
  import noc_pkg::*;

  port_mask_t head_route;
  port_mask_t route_q;
  logic       in_pkt_q;
  logic       transfer;

  // X first, then Y, local when both match
  always_comb begin
    head_route = '0;
    if (data_i.hdr.dst.x > xy_id_i.x) begin
      head_route[East] = 1'b1;
    end else if (data_i.hdr.dst.x < xy_id_i.x) begin
      head_route[West] = 1'b1;
    end else if (data_i.hdr.dst.y > xy_id_i.y) begin
      head_route[North] = 1'b1;
    end else if (data_i.hdr.dst.y < xy_id_i.y) begin
      head_route[South] = 1'b1;
    end else begin
      head_route[Eject] = 1'b1;
    end
  end

  assign transfer = valid_i & ready_i;
  assign route_o  = in_pkt_q ? route_q : head_route;
  assign data_o   = data_i;

  // Body flits follow the route taken by their head
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      in_pkt_q <= 1'b0;
      route_q  <= '0;
    end else if (transfer) begin
      if (data_i.hdr.last) begin
        in_pkt_q <= 1'b0;
      end else if (!in_pkt_q) begin
        in_pkt_q <= 1'b1;
        route_q  <= head_route;
      end
    end
  end

endmodule

`default_nettype wire

// ==== test/tb_router_model.svh ====
/* Reference model: XY output rule, legal destinations per input,
   expected flit queues, wormhole owners and compare tasks */
`ifndef TB_ROUTER_MODEL_SVH
`define TB_ROUTER_MODEL_SVH

localparam coord_t RouterId = '{x: 3'd3, y: 3'd3};

// Expected flits per input and output, oldest first
flit_t      exp_q       [NumPorts][NumPorts][$];
route_dir_e owner       [NumPorts];
logic       owner_valid [NumPorts];

function automatic route_dir_e xy_port(coord_t dst);
  if (dst.x != RouterId.x) begin
    return (dst.x > RouterId.x) ? East : West;
  end
  if (dst.y != RouterId.y) begin
    return (dst.y > RouterId.y) ? North : South;
  end
  return Eject;
endfunction

// Destinations that need neither loopback nor a Y-to-X turn
function automatic coord_t legal_dst(route_dir_e port);
  coord_t dst;
  dst.x = 3'(take_bits(3));
  dst.y = 3'(take_bits(3));
  case (port)
    North:   dst = '{x: RouterId.x, y: 3'(take_bits(2))};
    South:   dst = '{x: RouterId.x, y: 3'd3 + 3'(take_bits(2))};
    East:    dst.x = 3'(take_bits(2));
    West:    dst.x = 3'd3 + 3'(take_bits(2));
    // Local traffic never targets this router
    default: dst.y = (dst == RouterId) ? 3'd0 : dst.y;
  endcase
  return dst;
endfunction

task automatic check_flit(string name, flit_t got, flit_t exp);
  if (got !== exp) begin
    stop_on_error($sformatf("ERR %s: got 0x%h expected 0x%h", name, got, exp));
  end
endtask

task automatic check_port(string name, route_dir_e got, route_dir_e exp);
  if (got !== exp) begin
    stop_on_error($sformatf("ERR %s: got 0x%h expected 0x%h", name, got, exp));
  end
endtask

task automatic check_mask(string name, port_mask_t got, port_mask_t exp);
  if (got !== exp) begin
    stop_on_error($sformatf("ERR %s: got 0x%h expected 0x%h", name, got, exp));
  end
endtask

`endif

// ==== test/tb_noc_router.sv ====
/* Router testbench: clock and reset, LFSR packet stimulus with random
   back-pressure, checks against the reference model */
`timescale 1ns/1ps
`default_nettype none

module tb_noc_router;
  import noc_pkg::*;

  localparam int unsigned RunCycles   = 2000;
  localparam int unsigned DrainCycles = 400;

  logic                 clk;
  logic                 rst_n;
  logic  [NumPorts-1:0] in_valid;
  logic  [NumPorts-1:0] in_ready;
  flit_t [NumPorts-1:0] in_data;
  logic  [NumPorts-1:0] out_valid;
  logic  [NumPorts-1:0] out_ready;
  flit_t [NumPorts-1:0] out_data;

  logic [15:0]         lfsr_q;
  logic                gen_enable;
  logic [NumPorts-1:0] in_taken;
  int unsigned         flits_left  [NumPorts];
  coord_t              pkt_dst     [NumPorts];
  logic [12:0]         seq_cnt     [NumPorts];
  logic                hold_valid  [NumPorts];
  flit_t               hold_data   [NumPorts];
  int unsigned         flits_out;
  int unsigned         drain_cnt;

  // Fibonacci LFSR with taps 16 14 13 11 and one step per bit
  function automatic logic [15:0] take_bits(int unsigned n);
    logic [15:0] val;
    logic        fb;
    val = '0;
    for (int unsigned k = 0; k < n; k++) begin
      fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
      lfsr_q = {lfsr_q[14:0], fb};
      val    = {val[14:0], fb};
    end
    return val;
  endfunction

  task automatic stop_on_error(string msg);
    $display("%s", msg);
    $display("sim failed");
    $fatal(1, "stopped at the first error");
  endtask

  `include "tb_router_model.svh"

  noc_router u_dut (
    .clk_i   ( clk       ),
    .rst_n_i ( rst_n     ),
    .xy_id_i ( RouterId  ),
    .valid_i ( in_valid  ),
    .ready_o ( in_ready  ),
    .data_i  ( in_data   ),
    .valid_o ( out_valid ),
    .ready_i ( out_ready ),
    .data_o  ( out_data  )
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic drive_inputs();
    for (int p = 0; p < NumPorts; p++) begin
      // A raised valid keeps its flit until the router takes it
      if (in_valid[p] && !in_taken[p]) begin
        continue;
      end
      in_valid[p] = 1'b0;
      if (flits_left[p] == 0 && gen_enable && take_bits(2) != 0) begin
        flits_left[p] = 1 + int'(take_bits(2));
        pkt_dst[p]    = legal_dst(route_dir_e'(p));
      end
      if (flits_left[p] != 0) begin
        in_data[p].hdr.dst  = pkt_dst[p];
        in_data[p].hdr.src  = '{x: 3'(p), y: 3'(flits_left[p])};
        in_data[p].hdr.last = (flits_left[p] == 1);
        in_data[p].payload  = {3'(p), seq_cnt[p]};
        in_valid[p]         = 1'b1;
        seq_cnt[p]          = seq_cnt[p] + 1'b1;
        flits_left[p]       = flits_left[p] - 1;
      end
    end
    // About one output in four stalls per cycle
    for (int p = 0; p < NumPorts; p++) begin
      out_ready[p] = !gen_enable || (take_bits(2) != 0);
    end
  endtask

  task automatic sample_cycle();
    route_dir_e src;
    flit_t      exp;
    string      name;
    for (int p = 0; p < NumPorts; p++) begin
      in_taken[p] = in_valid[p] & in_ready[p];
      if (in_taken[p]) begin
        exp_q[p][xy_port(in_data[p].hdr.dst)].push_back(in_data[p]);
      end
    end
    for (int o = 0; o < NumPorts; o++) begin
      name = $sformatf("data_o[%0d]", o);
      if (hold_valid[o] && !out_valid[o]) begin
        stop_on_error($sformatf("valid_o[%0d] dropped while its flit was stalled", o));
      end
      if (hold_valid[o]) begin
        check_flit(name, out_data[o], hold_data[o]);
      end
      hold_valid[o] = out_valid[o] & !out_ready[o];
      hold_data[o]  = out_data[o];
      if (out_valid[o] && out_ready[o]) begin
        check_port({name, " route"}, route_dir_e'(o), xy_port(out_data[o].hdr.dst));
        if (out_data[o].payload[15:13] >= NumPorts) begin
          stop_on_error($sformatf("ERR %s payload: 0x%h names no input port",
                                  name, out_data[o].payload));
        end
        src = route_dir_e'(out_data[o].payload[15:13]);
        if (owner_valid[o]) begin
          check_port({name, " source"}, src, owner[o]);
        end
        if (exp_q[src][o].size() == 0) begin
          stop_on_error($sformatf("output %0d sent a flit from input %0d that was never accepted",
                                  o, src));
        end else begin
          exp = exp_q[src][o].pop_front();
          check_flit(name, out_data[o], exp);
        end
        owner[o]       = src;
        owner_valid[o] = !out_data[o].hdr.last;
        flits_out++;
      end
    end
  endtask

  task automatic run_cycle();
    @(posedge clk);
    #1;
    drive_inputs();
    @(negedge clk);
    sample_cycle();
  endtask

  function automatic logic all_idle();
    for (int p = 0; p < NumPorts; p++) begin
      if (in_valid[p] || flits_left[p] != 0) begin
        return 1'b0;
      end
      for (int o = 0; o < NumPorts; o++) begin
        if (exp_q[p][o].size() != 0) begin
          return 1'b0;
        end
      end
    end
    return 1'b1;
  endfunction

  task automatic check_reset_state();
    check_mask("valid_o", out_valid, '0);
    check_mask("ready_o", in_ready, '1);
  endtask

  initial begin
    rst_n      = 1'b0;
    in_valid   = '0;
    in_data    = '0;
    out_ready  = '0;
    in_taken   = '0;
    gen_enable = 1'b0;
    lfsr_q     = 16'd49057;
    flits_out  = 0;
    drain_cnt  = 0;
    for (int p = 0; p < NumPorts; p++) begin
      flits_left[p]  = 0;
      pkt_dst[p]     = '0;
      seq_cnt[p]     = '0;
      owner[p]       = North;
      owner_valid[p] = 1'b0;
      hold_valid[p]  = 1'b0;
      hold_data[p]   = '0;
    end
    repeat (3) begin
      @(posedge clk);
      #1;
      check_reset_state();
    end
    rst_n = 1'b1;
    @(negedge clk);
    check_reset_state();

    gen_enable = 1'b1;
    repeat (RunCycles) begin
      run_cycle();
    end

    // Open packets finish and the router empties with every output ready
    gen_enable = 1'b0;
    while (!all_idle() && drain_cnt < DrainCycles) begin
      run_cycle();
      drain_cnt++;
    end
    // Any flit in the quiet period would be a duplicate
    repeat (20) begin
      run_cycle();
    end

    if (!all_idle()) begin
      stop_on_error("timeout while waiting for the router to deliver every accepted flit");
    end else if (flits_out == 0) begin
      stop_on_error("no flit left the router during the run");
    end else begin
      $display("sim passed");
      $finish;
    end
  end

endmodule

`default_nettype wire
